// File: fetch_pkg.sv
/*
  Types shared by the prefetch blocks and the testbench.
  Addresses are byte addresses; the bus only ever sees word-aligned ones.
*/
`default_nettype none

package fetch_pkg;

  // Byte address of an instruction or a memory word
  typedef logic [31:0] addr_t;

  // One memory data word
  typedef logic [31:0] word_t;

  // Read request on the memory bus
  typedef struct packed {
    addr_t addr;      // Word aligned
  } mem_req_t;

  // Read response on the memory bus
  typedef struct packed {
    word_t rdata;
    logic  err;
  } mem_rsp_t;

  // Realigned instruction leaving the fetch FIFO
  // Upper half of instr is don't care for a compressed instruction
  typedef struct packed {
    addr_t addr;
    word_t instr;
    logic  err;
  } fetch_item_t;

  // Instruction as handed to decode
  typedef struct packed {
    addr_t pc;
    word_t instr;
    logic  compressed;
    logic  err;
  } instr_t;

  // Reads in flight on the bus by default
  localparam int unsigned NumReqsDefault = 2;

endpackage

`default_nettype wire

// File: fetch_req_ctrl.sv
/*
  Issues word reads on a req/gnt/rvalid bus, at most NUM_REQS in flight.
  Idle until the first branch. Responses to reads issued before a branch
  are counted and dropped, never forwarded.
*/
`default_nettype none

module fetch_req_ctrl #(
  parameter int unsigned NUM_REQS = 2
) (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,

  // Branch strobe and target
  input  wire logic               branch_i,
  input  wire fetch_pkg::addr_t   branch_addr_i,

  // Memory bus
  output logic                    mem_req_o,
  output fetch_pkg::mem_req_t     mem_req_data_o,
  input  wire logic               mem_gnt_i,
  input  wire logic               mem_rvalid_i,
  input  wire fetch_pkg::mem_rsp_t mem_rsp_i,

  // Towards the fetch FIFO
  output logic                    fifo_in_valid_o,
  output fetch_pkg::mem_rsp_t     fifo_in_rsp_o,
  input  wire logic               fifo_in_ready_i
);

  // Counter wide enough to hold NUM_REQS
  localparam int unsigned CntW = $clog2(NUM_REQS + 1);

  fetch_pkg::addr_t addr_q;
  logic             active_q;
  logic             pending_q;
  logic             issue_ok;
  logic             req_granted;
  logic [CntW-1:0]  outstanding_q, outstanding_d;
  logic [CntW-1:0]  discard_q, discard_d;
  logic             rsp_stale;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  // New read only with FIFO room reserved and a free bus slot
  assign issue_ok = active_q & fifo_in_ready_i & (outstanding_q < CntW'(NUM_REQS));

  // A request once raised stays up until granted
  assign mem_req_o           = pending_q | issue_ok;
  assign mem_req_data_o.addr = addr_q;
  assign req_granted         = mem_req_o & mem_gnt_i;

  // Fetch address
  // Branch restarts at the word holding the target
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (branch_i) begin
      addr_q <= {branch_addr_i[31:2], 2'b00};
    end else if (req_granted) begin
      addr_q <= addr_q + fetch_pkg::addr_t'(4);
    end
  end

  // Active from the first branch on, pending while waiting for gnt
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q  <= 1'b0;
      pending_q <= 1'b0;
    end else begin
      if (branch_i) begin
        active_q <= 1'b1;
      end
      pending_q <= mem_req_o & ~mem_gnt_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outstanding and stale reads
  ////////////////////////////////////////////////////////////

  // Grants minus responses
  always_comb begin
    outstanding_d = outstanding_q;
    if (req_granted && !mem_rvalid_i) begin
      outstanding_d = outstanding_q + CntW'(1);
    end else if (!req_granted && mem_rvalid_i) begin
      outstanding_d = outstanding_q - CntW'(1);
    end
  end

  // On a branch everything still in flight turns stale
  // A grant in the branch cycle is for the old address, so it counts too
  always_comb begin
    discard_d = discard_q;
    if (branch_i) begin
      discard_d = outstanding_d;
    end else if (mem_rvalid_i && rsp_stale) begin
      discard_d = discard_q - CntW'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
      discard_q     <= '0;
    end else begin
      outstanding_q <= outstanding_d;
      discard_q     <= discard_d;
    end
  end

  assign rsp_stale = (discard_q != '0);

  ////////////////////////////////////////////////////////////
  // Response forwarding
  ////////////////////////////////////////////////////////////

  // Same cycle as rvalid, no back-pressure possible
  // A response in the branch cycle is dropped by the FIFO clear
  assign fifo_in_valid_o = mem_rvalid_i & ~rsp_stale;
  assign fifo_in_rsp_o   = mem_rsp_i;

endmodule

`default_nettype wire

// File: fetch_fifo.sv
/*
  Realigning fetch FIFO, NUM_REQS+1 words deep, entry zero at the output.
  Upstream must keep in_valid_i low unless room was reserved (in_ready_o).
  clear_i also drops any word arriving in the same cycle.
*/
`default_nettype none

module fetch_fifo #(
  parameter int unsigned NUM_REQS = 2
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,

  // Branch: flush and load new address
  input  wire logic                clear_i,

  // Incoming memory words
  input  wire logic                in_valid_i,
  output logic                     in_ready_o,
  input  wire fetch_pkg::addr_t    in_addr_i,
  input  wire fetch_pkg::mem_rsp_t in_rsp_i,

  // Outgoing instructions
  output logic                     out_valid_o,
  input  wire logic                out_ready_i,
  output fetch_pkg::fetch_item_t   out_o
);

  localparam int unsigned DEPTH = NUM_REQS + 1;

  // Storage
  fetch_pkg::mem_rsp_t [DEPTH-1:0] fifo_q, fifo_d;
  fetch_pkg::mem_rsp_t [DEPTH-1:0] sh_data;
  logic [DEPTH-1:0]                valid_q, valid_d;
  logic [DEPTH-1:0]                sh_valid;

  // Head word and the word after it, either may come from the bypass
  fetch_pkg::mem_rsp_t head_word, next_word;
  logic                head_valid, next_valid;

  fetch_pkg::addr_t    addr_q;
  logic [15:0]         first_hw;
  logic                is_comp;
  logic                transfer;
  logic                pop;
  logic                push;

  ////////////////////////////////////////////////////////////
  // Head selection and alignment
  ////////////////////////////////////////////////////////////

  // Empty FIFO passes the incoming word straight through
  assign head_word  = valid_q[0] ? fifo_q[0] : in_rsp_i;
  assign head_valid = valid_q[0] | in_valid_i;

  // Second word for a straddling instruction
  assign next_word  = valid_q[1] ? fifo_q[1] : in_rsp_i;
  assign next_valid = valid_q[1] | (valid_q[0] & in_valid_i);

  // First halfword of the current instruction
  assign first_hw = addr_q[1] ? head_word.rdata[31:16] : head_word.rdata[15:0];
  assign is_comp  = (first_hw[1:0] != 2'b11);

  always_comb begin
    out_o.addr = addr_q;
    if (!addr_q[1]) begin
      // Word aligned, all from the head
      out_o.instr = head_word.rdata;
      out_o.err   = head_word.err;
      out_valid_o = head_valid;
    end else begin
      // Halfword offset
      // Upper half of head, lower half of the next word
      out_o.instr = {next_word.rdata[15:0], head_word.rdata[31:16]};
      // Next word only matters for a full-size instruction
      out_o.err   = head_word.err | (~is_comp & next_word.err);
      out_valid_o = is_comp ? head_valid : next_valid;
    end
  end

  assign transfer = out_valid_o & out_ready_i;

  ////////////////////////////////////////////////////////////
  // Instruction address
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (clear_i) begin
      addr_q <= in_addr_i;
    end else if (transfer) begin
      // Step over a halfword or a full word
      addr_q <= addr_q + (is_comp ? fetch_pkg::addr_t'(2) : fetch_pkg::addr_t'(4));
    end
  end

  ////////////////////////////////////////////////////////////
  // FIFO management
  ////////////////////////////////////////////////////////////

  // Room for NUM_REQS more words only while entry one is free
  assign in_ready_o = ~valid_q[1];

  // Head word is done once its upper halfword has been used
  // Aligned compressed leaves the upper half for the next instruction
  assign pop = transfer & (addr_q[1] | ~is_comp);

  // A bypassed word that is fully used never gets stored
  assign push = in_valid_i & ~(pop & ~valid_q[0]);

  // Shift down by one entry on a pop
  always_comb begin
    for (int i = 0; i < DEPTH - 1; i++) begin
      sh_valid[i] = pop ? valid_q[i+1] : valid_q[i];
      sh_data[i]  = pop ? fifo_q[i+1]  : fifo_q[i];
    end
    sh_valid[DEPTH-1] = pop ? 1'b0 : valid_q[DEPTH-1];
    sh_data[DEPTH-1]  = fifo_q[DEPTH-1];
  end

  // Write the incoming word into the lowest free entry after the shift
  always_comb begin
    logic slot_found;
    slot_found = 1'b0;
    valid_d    = sh_valid;
    fifo_d     = sh_data;
    for (int i = 0; i < DEPTH; i++) begin
      if (!sh_valid[i] && !slot_found) begin
        slot_found = 1'b1;
        if (push) begin
          valid_d[i] = 1'b1;
          fifo_d[i]  = in_rsp_i;
        end
      end
    end
    // Branch empties everything
    if (clear_i) begin
      valid_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // Data words, qualified by valid_q
  always_ff @(posedge clk_i) begin
    fifo_q <= fifo_d;
  end

endmodule

`default_nettype wire

// File: instr_predecode.sv
/*
  One-entry output register towards decode.
  Compressed instructions leave with the upper 16 bits zeroed, not expanded.
*/
`default_nettype none

module instr_predecode (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,

  // Branch: drop the held instruction
  input  wire logic                  flush_i,

  // From the fetch FIFO
  input  wire logic                  in_valid_i,
  output logic                       in_ready_o,
  input  wire fetch_pkg::fetch_item_t in_i,

  // To decode
  output logic                       out_valid_o,
  input  wire logic                  out_ready_i,
  output fetch_pkg::instr_t          out_o
);

  logic              valid_q;
  fetch_pkg::instr_t instr_q, instr_d;
  logic              accept;
  logic              in_comp;

  // Take a new item when empty or when the held one leaves now
  // Nothing enters in the flush cycle
  assign in_ready_o = ~flush_i & (~valid_q | out_ready_i);
  assign accept     = in_valid_i & in_ready_o;

  // Predecode
  assign in_comp = (in_i.instr[1:0] != 2'b11);

  always_comb begin
    instr_d.pc         = in_i.addr;
    instr_d.compressed = in_comp;
    instr_d.err        = in_i.err;
    instr_d.instr      = in_comp ? {16'h0000, in_i.instr[15:0]} : in_i.instr;
  end

  // Valid flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      instr_q <= instr_d;
    end
  end

  assign out_valid_o = valid_q;
  assign out_o       = instr_q;

endmodule

`default_nettype wire

// File: prefetch_top.sv
/*
  Instruction prefetch: request controller, realigning FIFO, output stage.
  Nothing is fetched before the first branch_i after reset.
*/
`default_nettype none

module prefetch_top #(
  parameter int unsigned NUM_REQS = fetch_pkg::NumReqsDefault
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,

  // Branch strobe, halfword-aligned target
  input  wire logic                branch_i,
  input  wire fetch_pkg::addr_t    branch_addr_i,

  // Memory bus
  output logic                     mem_req_o,
  output fetch_pkg::mem_req_t      mem_req_o_data,
  input  wire logic                mem_gnt_i,
  input  wire logic                mem_rvalid_i,
  input  wire fetch_pkg::mem_rsp_t mem_rsp_i,

  // Decode side
  output logic                     instr_valid_o,
  input  wire logic                instr_ready_i,
  output fetch_pkg::instr_t        instr_o
);

  // Controller to FIFO
  logic                   fifo_in_valid;
  logic                   fifo_in_ready;
  fetch_pkg::mem_rsp_t    fifo_in_rsp;

  // FIFO to output stage
  logic                   fifo_out_valid;
  logic                   fifo_out_ready;
  fetch_pkg::fetch_item_t fifo_out;

  fetch_req_ctrl #(
    .NUM_REQS (NUM_REQS)
  ) i_req_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .branch_i        (branch_i),
    .branch_addr_i   (branch_addr_i),
    .mem_req_o       (mem_req_o),
    .mem_req_data_o  (mem_req_o_data),
    .mem_gnt_i       (mem_gnt_i),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rsp_i       (mem_rsp_i),
    .fifo_in_valid_o (fifo_in_valid),
    .fifo_in_rsp_o   (fifo_in_rsp),
    .fifo_in_ready_i (fifo_in_ready)
  );

  fetch_fifo #(
    .NUM_REQS (NUM_REQS)
  ) i_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (branch_i),
    .in_valid_i  (fifo_in_valid),
    .in_ready_o  (fifo_in_ready),
    .in_addr_i   (branch_addr_i),
    .in_rsp_i    (fifo_in_rsp),
    .out_valid_o (fifo_out_valid),
    .out_ready_i (fifo_out_ready),
    .out_o       (fifo_out)
  );

  instr_predecode i_predecode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (branch_i),
    .in_valid_i  (fifo_out_valid),
    .in_ready_o  (fifo_out_ready),
    .in_i        (fifo_out),
    .out_valid_o (instr_valid_o),
    .out_ready_i (instr_ready_i),
    .out_o       (instr_o)
  );

endmodule

`default_nettype wire

// File: tb_mem_model.sv
/*
  Memory responder for the prefetch testbench. Grants after 0 to 2 cycles,
  answers in order 1 to 3 cycles after the grant, never back-pressures.
  Contents are computed from the address; words in [ERR_LO, ERR_HI) set err.
*/
`default_nettype none

module tb_mem_model #(
  parameter fetch_pkg::addr_t ERR_LO = 32'h0000_110c,
  parameter fetch_pkg::addr_t ERR_HI = 32'h0000_1114,
  parameter logic [31:0]      SEED   = 32'hea7f_1e29
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                req_i,
  input  wire fetch_pkg::mem_req_t req_data_i,
  output logic                     gnt_o,
  output logic                     rvalid_o,
  output fetch_pkg::mem_rsp_t      rsp_o,
  output int unsigned              outstanding_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Granted reads waiting for their response, oldest first
  fetch_pkg::addr_t pend_addr[$];
  int unsigned      pend_due[$];

  int unsigned      cyc;
  int unsigned      last_due;
  int unsigned      due;
  int unsigned      gnt_wait;
  logic [31:0]      rnd;
  logic             accepted;
  fetch_pkg::addr_t rsp_addr;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Halfword stored at byte address a
  // Size marker from an address parity hash, payload from a multiplicative hash
  function automatic logic [15:0] halfword_at(input fetch_pkg::addr_t a);
    logic [31:0] mix;
    logic        full;
    mix  = a * 32'h9e37_79b9;
    full = ^(a[8:1] & 8'hb5);
    if (full) begin
      return {mix[31:18], 2'b11};
    end else begin
      // Low bits 00 or 10, never a full-size marker
      return {mix[31:18], mix[17], 1'b0};
    end
  endfunction

  // Error window on word addresses
  function automatic logic word_err(input fetch_pkg::addr_t a);
    return (a >= ERR_LO) && (a < ERR_HI);
  endfunction

  ////////////////////////////////////////////////////////////
  // Grant, queue and respond
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_addr.delete();
      pend_due.delete();
      cyc           = 0;
      last_due      = 0;
      rnd           = lcg_next(SEED);
      gnt_wait      = rnd[31:16] % 3;
      gnt_o         <= (gnt_wait == 0);
      rvalid_o      <= 1'b0;
      rsp_o         <= '0;
      outstanding_o <= 0;
    end else begin
      cyc      = cyc + 1;
      accepted = req_i && gnt_o;
      if (accepted) begin
        // Response 1 to 3 cycles on, never before an older one
        rnd = lcg_next(rnd);
        due = cyc + (rnd[31:16] % 3);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        pend_addr.push_back(req_data_i.addr);
        pend_due.push_back(due);
        // Fresh grant delay for the next request
        rnd      = lcg_next(rnd);
        gnt_wait = rnd[31:16] % 3;
      end else if (req_i && gnt_wait != 0) begin
        gnt_wait = gnt_wait - 1;
      end
      gnt_o <= (gnt_wait == 0);

      if (pend_due.size() != 0 && pend_due[0] <= cyc) begin
        rsp_addr = pend_addr.pop_front();
        void'(pend_due.pop_front());
        rvalid_o    <= 1'b1;
        rsp_o.rdata <= {halfword_at(rsp_addr + 32'd2), halfword_at(rsp_addr)};
        rsp_o.err   <= word_err(rsp_addr);
      end else begin
        rvalid_o <= 1'b0;
      end

      // Grants minus responses
      outstanding_o <= outstanding_o + (accepted ? 1 : 0) - (rvalid_o ? 1 : 0);
    end
  end

endmodule

`default_nettype wire

// File: tb_prefetch.sv
/*
  Testbench for prefetch_top. Each table row branches to a target and
  consumes a number of instructions under a ready pattern or random stalls.
  Every instruction is compared with a model of the memory contents rule.
*/
`default_nettype none

module tb_prefetch;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NUM_REQS   = fetch_pkg::NumReqsDefault;
  localparam int unsigned NUM_ROWS   = 8;
  localparam int unsigned IDLE_LIMIT = 200;
  localparam logic [31:0] SEED       = 32'hea7f_1e29;

  // One stimulus row
  typedef struct packed {
    fetch_pkg::addr_t target;
    logic [15:0]      count;
    logic [7:0]       ready_mask;   // Bit i drives ready in step i of every eight
    logic             rnd_stall;    // Random ready instead of the mask
  } row_t;

  logic                   clk;
  logic                   rst_n;
  logic                   branch;
  fetch_pkg::addr_t       branch_addr;
  logic                   mem_req;
  fetch_pkg::mem_req_t    mem_req_data;
  logic                   mem_gnt;
  logic                   mem_rvalid;
  fetch_pkg::mem_rsp_t    mem_rsp;
  logic                   instr_valid;
  logic                   instr_ready;
  fetch_pkg::instr_t      instr;
  int unsigned            mem_outstanding;

  row_t                   rows [NUM_ROWS];
  fetch_pkg::addr_t       model_pc;
  logic [31:0]            stall_rnd;

  // Request left waiting for its grant in the previous cycle
  logic                   held_req;
  fetch_pkg::addr_t       held_addr;

  prefetch_top #(
    .NUM_REQS (NUM_REQS)
  ) i_dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .branch_i       (branch),
    .branch_addr_i  (branch_addr),
    .mem_req_o      (mem_req),
    .mem_req_o_data (mem_req_data),
    .mem_gnt_i      (mem_gnt),
    .mem_rvalid_i   (mem_rvalid),
    .mem_rsp_i      (mem_rsp),
    .instr_valid_o  (instr_valid),
    .instr_ready_i  (instr_ready),
    .instr_o        (instr)
  );

  tb_mem_model #(
    .SEED (SEED)
  ) i_mem (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .req_i         (mem_req),
    .req_data_i    (mem_req_data),
    .gnt_o         (mem_gnt),
    .rvalid_o      (mem_rvalid),
    .rsp_o         (mem_rsp),
    .outstanding_o (mem_outstanding)
  );

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic stop_failed();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped after a failure");
  endtask

  task automatic report_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    stop_failed();
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic row_t make_row(input fetch_pkg::addr_t target, input int unsigned count,
                                    input logic [7:0] mask, input logic rnd);
    row_t r;
    r.target     = target;
    r.count      = 16'(count);
    r.ready_mask = mask;
    r.rnd_stall  = rnd;
    return r;
  endfunction

  // Next instruction in program order from model_pc, then step over it
  task automatic predict_next(output fetch_pkg::instr_t exp);
    logic [15:0]      lo;
    logic [15:0]      hi;
    fetch_pkg::addr_t hi_pc;
    hi_pc = model_pc + 32'd2;
    lo    = i_mem.halfword_at(model_pc);
    hi    = i_mem.halfword_at(hi_pc);
    exp.pc = model_pc;
    if (lo[1:0] != 2'b11) begin
      exp.compressed = 1'b1;
      exp.instr      = {16'h0000, lo};
      exp.err        = i_mem.word_err({model_pc[31:2], 2'b00});
      model_pc       = model_pc + 32'd2;
    end else begin
      // Upper half may sit in the next word
      exp.compressed = 1'b0;
      exp.instr      = {hi, lo};
      exp.err        = i_mem.word_err({model_pc[31:2], 2'b00})
                     | i_mem.word_err({hi_pc[31:2], 2'b00});
      model_pc       = model_pc + 32'd4;
    end
  endtask

  task automatic check_instr(input fetch_pkg::instr_t exp);
    assert (instr.pc == exp.pc)
      else report_error($sformatf("pc got %h expected %h", instr.pc, exp.pc));
    assert (instr.instr == exp.instr)
      else report_error($sformatf("instr at %h got %h expected %h",
                                  exp.pc, instr.instr, exp.instr));
    assert (instr.compressed == exp.compressed)
      else report_error($sformatf("compressed at %h got %b expected %b",
                                  exp.pc, instr.compressed, exp.compressed));
    assert (instr.err == exp.err)
      else report_error($sformatf("err at %h got %b expected %b",
                                  exp.pc, instr.err, exp.err));
  endtask

  // Branch, then consume row.count instructions
  task automatic run_row(input row_t row);
    fetch_pkg::instr_t exp;
    int unsigned       got;
    int unsigned       idle;
    int unsigned       step;
    logic              rdy;
    got      = 0;
    idle     = 0;
    step     = 0;
    model_pc = row.target;
    // Branch cycle, decode side takes nothing
    @(posedge clk);
    branch      <= 1'b1;
    branch_addr <= row.target;
    instr_ready <= 1'b0;
    while (got < row.count) begin
      if (row.rnd_stall) begin
        stall_rnd = lcg_next(stall_rnd);
        rdy       = stall_rnd[31];
      end else begin
        rdy = row.ready_mask[step % 8];
      end
      step++;
      @(posedge clk);
      branch      <= 1'b0;
      instr_ready <= rdy;
      // Mid-cycle, valid and ready are settled
      @(negedge clk);
      if (instr_valid && instr_ready) begin
        predict_next(exp);
        check_instr(exp);
        got++;
        idle = 0;
      end else begin
        idle++;
        if (idle >= IDLE_LIMIT) begin
          $display("Timeout: no instruction delivered for %0d cycles after target %h",
                   IDLE_LIMIT, row.target);
          stop_failed();
        end
      end
    end
  endtask

  // Bus limits seen from the memory side
  // An ungranted request stays up with its address unless a branch replaced it
  always @(negedge clk) begin
    if (rst_n) begin
      assert (mem_outstanding <= NUM_REQS)
        else report_error($sformatf("%0d reads outstanding, limit is %0d",
                                    mem_outstanding, NUM_REQS));
      assert (!held_req || (mem_req && mem_req_data.addr == held_addr))
        else report_error($sformatf("request for %h dropped or changed before grant",
                                    held_addr));
      held_req  = mem_req && !mem_gnt && !branch;
      held_addr = mem_req_data.addr;
    end else begin
      held_req  = 1'b0;
      held_addr = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus table and main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n       = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    instr_ready = 1'b0;
    model_pc    = '0;
    stall_rnd   = SEED;

    // Boot branch, word aligned, sequential stream
    rows[0] = make_row(32'h0000_1000, 40, 8'hff, 1'b0);
    // Halfword offset target, first instruction straddles
    rows[1] = make_row(32'h0000_2002, 30, 8'hff, 1'b0);
    // Short runs, branch away with reads in flight and a queue filled
    rows[2] = make_row(32'h0000_6000, 2, 8'hff, 1'b0);
    rows[3] = make_row(32'h0000_6100, 1, 8'h11, 1'b0);
    rows[4] = make_row(32'h0000_7ffe, 20, 8'h5a, 1'b0);
    // Across the error window, neighbours without err
    rows[5] = make_row(32'h0000_10f0, 40, 8'hff, 1'b0);
    // Straddling instruction with only its upper half in the window
    rows[6] = make_row(32'h0000_110a, 12, 8'h77, 1'b0);
    // Long run with random stalls
    rows[7] = make_row(32'h0000_5000, 80, 8'h00, 1'b1);

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows[i]);
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
fetch_pkg.sv
fetch_req_ctrl.sv
fetch_fifo.sv
instr_predecode.sv
prefetch_top.sv
tb_mem_model.sv
tb_prefetch.sv
